// ==== include/timer_defs.svh ====
/*
 * interval timer reset defaults
 * control words and reload values loaded into each counter at reset
 */
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// control word layout: sc[7:6] rw[5:4] mode[3:1] bcd[0]

// counter 0, system tick, lsb/msb, mode 3
`define TIMER_CW0_0 8'h36
// counter 1, refresh strobe, lsb only, mode 2
`define TIMER_CW0_1 8'h54
// counter 2, speaker tone, lsb/msb, mode 3
`define TIMER_CW0_2 8'hB6

// reload values
`define TIMER_CR0_0 16'hFFFF  // full 16-bit period
`define TIMER_CR0_1 16'h0012  // short refresh period
`define TIMER_CR0_2 16'h04A9  // ~1 kHz tone at 1.19 MHz

`endif

// ==== hdl/timer_pkg.sv ====
/*
 * interval timer types
 * control word fields, mode and access encodings
 */
package timer_pkg;

  // counting modes, anything else runs as rate generator
  typedef enum logic [2:0] {
    MODE_RATE   = 3'd2,  // mode 2
    MODE_SQUARE = 3'd3   // mode 3
  } timer_mode_e;

  // read/write access sequencing
  typedef enum logic [1:0] {
    RW_LATCH = 2'b00,  // counter latch command
    RW_LSB   = 2'b01,
    RW_MSB   = 2'b10,
    RW_WORD  = 2'b11   // lsb then msb
  } timer_rw_e;

  // mode program byte
  typedef struct packed {
    logic [1:0]  sc;    // counter select
    timer_rw_e   rw;
    timer_mode_e mode;
    logic        bcd;   // binary only here
  } timer_cw_t;

  // latch command byte, rw reads 00
  typedef struct packed {
    logic [1:0] sc;
    logic [1:0] rw;
    logic [3:0] unused;
  } timer_latch_t;

  // one written control byte, two decodes
  typedef union packed {
    timer_cw_t    cw;
    timer_latch_t latch;
  } timer_ctrl_u;

endpackage

// ==== hdl/timer_cnt_if.sv ====
/*
 * per-counter bus link
 * strobes and byte data between the wishbone port and one counter
 */
`timescale 1ns/1ps

interface timer_cnt_if;

  logic       wrc;     // control word write, broadcast
  logic       wrd;     // data write to this counter
  logic       rdd;     // data read from this counter
  logic [7:0] data_w;  // byte from the bus lane
  logic [7:0] data_r;  // byte back to the bus

  // port side
  modport bus (
    output wrc, wrd, rdd, data_w,
    input  data_r
  );

  // counter side
  modport counter (
    input  wrc, wrd, rdd, data_w,
    output data_r
  );

endinterface

// ==== hdl/timer_tclk_sync.sv ====
/*
 * timer clock synchronizer
 * brings tclk into the bus domain, one tick per rising edge
 */
`timescale 1ns/1ps

module timer_tclk_sync (
  input  logic wb_clk_i,
  input  logic rst_i,
  input  logic tclk_i,   // slow, asynchronous
  output logic tick_o    // one cycle enable
);

  logic tclk_s1;  // metastability stage
  logic tclk_s2;  // synchronized level
  logic tclk_s3;  // previous level

  always_ff @(posedge wb_clk_i)
  begin
    if (rst_i)
    begin
      tclk_s1 <= 1'b0;
      tclk_s2 <= 1'b0;
      tclk_s3 <= 1'b0;
      tick_o  <= 1'b0;
    end
    else
    begin
      tclk_s1 <= tclk_i;
      tclk_s2 <= tclk_s1;
      tclk_s3 <= tclk_s2;
      tick_o  <= tclk_s2 & ~tclk_s3;  // third edge after tclk rises
    end
  end

endmodule

// ==== hdl/timer_wb_port.sv ====
/*
 * wishbone slave port of the interval timer
 * single cycle decode, byte lane steering, read mux, irq pulse
 */
`timescale 1ns/1ps

module timer_wb_port (
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  logic        wb_adr_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [15:0] wb_dat_i,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  input  logic        wb_we_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_tgc_o,   // one cycle interrupt
  input  logic        intr_i,     // counter 0 output
  timer_cnt_if.bus    cnt0_if,
  timer_cnt_if.bus    cnt1_if,
  timer_cnt_if.bus    cnt2_if
);

  logic [1:0] datasel;  // {adr, sel[1]}
  logic       lane_en;  // some byte lane enabled
  logic       wr_cyc;
  logic       rd_cyc;
  logic [7:0] data_i;   // steered write byte
  logic       intr_q;   // intr history

  // no wait states, ack in the strobe cycle
  assign wb_ack_o = wb_stb_i & wb_cyc_i;

  assign datasel = {wb_adr_i, wb_sel_i[1]};
  assign lane_en = |wb_sel_i;
  assign wr_cyc  = wb_ack_o & lane_en & wb_we_i;
  assign rd_cyc  = wb_ack_o & lane_en & ~wb_we_i;

  // odd ports sit on the high lane
  assign data_i = datasel[0] ? wb_dat_i[15:8] : wb_dat_i[7:0];

  // control word goes to everyone, counters match sc themselves
  assign cnt0_if.wrc = wr_cyc & (datasel == 2'b11);
  assign cnt1_if.wrc = wr_cyc & (datasel == 2'b11);
  assign cnt2_if.wrc = wr_cyc & (datasel == 2'b11);

  assign cnt0_if.wrd = wr_cyc & (datasel == 2'b00);
  assign cnt1_if.wrd = wr_cyc & (datasel == 2'b01);
  assign cnt2_if.wrd = wr_cyc & (datasel == 2'b10);

  assign cnt0_if.rdd = rd_cyc & (datasel == 2'b00);
  assign cnt1_if.rdd = rd_cyc & (datasel == 2'b01);
  assign cnt2_if.rdd = rd_cyc & (datasel == 2'b10);

  assign cnt0_if.data_w = data_i;
  assign cnt1_if.data_w = data_i;
  assign cnt2_if.data_w = data_i;

  // read data back into its lane, other lane zero
  always_comb
  begin
    case (datasel)
      2'b00:   wb_dat_o = {8'h00, cnt0_if.data_r};
      2'b01:   wb_dat_o = {cnt1_if.data_r, 8'h00};
      2'b10:   wb_dat_o = {8'h00, cnt2_if.data_r};
      default: wb_dat_o = 16'h0000;  // control reg is write only
    endcase
  end

  // rising edge of counter 0 out -> single pulse
  always_ff @(posedge wb_clk_i)
  begin
    if (rst_i)
    begin
      intr_q   <= 1'b1;  // counter 0 out is high after reset
      wb_tgc_o <= 1'b0;
    end
    else
    begin
      intr_q   <= intr_i;
      wb_tgc_o <= intr_i & ~intr_q;
    end
  end

endmodule

// ==== hdl/timer_counter.sv ====
/*
 * one programmable timer counter
 * binary modes 2 and 3, lsb/msb access sequencing, counter latch, gate
 */
`timescale 1ns/1ps

module timer_counter
  import timer_pkg::*;
#(
  parameter logic [1:0]  CNT_NUM = 2'd0,      // matched against sc
  parameter logic [7:0]  CNT_CW0 = 8'h36,     // control word after reset
  parameter logic [15:0] CNT_CR0 = 16'hFFFF   // reload after reset
) (
  input  logic         wb_clk_i,
  input  logic         rst_i,
  input  logic         tick_i,    // synchronized tclk edge
  input  logic         gate_i,
  timer_cnt_if.counter bus,
  output logic         out_o
);

  timer_ctrl_u ctrl;       // written control byte
  timer_cw_t   cw;         // current program
  logic [15:0] cr;         // reload register
  logic [15:0] count;      // down counter
  logic [15:0] ol;         // output latch
  logic [16:0] cr_full;    // reload with 0 as 65536
  logic [15:0] next_cnt;
  logic [15:0] rd_val;
  logic        next_out;
  logic        ctrl_hit;   // control byte names this counter
  logic        mode_sq;
  logic        run;        // has a count to work on
  logic        load_pend;  // new count waits for a tick
  logic        latched;    // ol holds a frozen count
  logic        wr_msb;     // next data write is the msb
  logic        rd_msb;     // next data read is the msb
  logic        gate_q;

  assign ctrl     = timer_ctrl_u'(bus.data_w);
  assign ctrl_hit = bus.wrc & (ctrl.latch.sc == CNT_NUM);
  assign mode_sq  = (cw.mode == MODE_SQUARE);   // other codes act as mode 2
  assign cr_full  = (cr == 16'h0000) ? 17'h10000 : {1'b0, cr};

  // step: reload on a new count or at terminal 1
  always_comb
  begin
    if (load_pend || count == 16'h0001)
      next_cnt = cr;
    else
      next_cnt = count - 16'h0001;  // 0 wraps to ffff
  end

  // mode 3 high while count above N/2, mode 2 low only at 1
  always_comb
  begin
    if (mode_sq)
      next_out = {next_cnt == 16'h0000, next_cnt} > {1'b0, cr_full[16:1]};
    else
      next_out = (next_cnt != 16'h0001);
  end

  // read side, latched value wins over live count
  assign rd_val = latched ? ol : count;

  always_comb
  begin
    case (cw.rw)
      RW_MSB:  bus.data_r = rd_val[15:8];
      RW_WORD: bus.data_r = rd_msb ? rd_val[15:8] : rd_val[7:0];
      default: bus.data_r = rd_val[7:0];
    endcase
  end

  always_ff @(posedge wb_clk_i)
  begin
    if (rst_i)
    begin
      cw        <= timer_cw_t'(CNT_CW0);
      cr        <= CNT_CR0;
      count     <= CNT_CR0;
      out_o     <= 1'b1;
      run       <= 1'b1;
      load_pend <= 1'b0;
      latched   <= 1'b0;
      wr_msb    <= 1'b0;
      rd_msb    <= 1'b0;
      gate_q    <= 1'b1;   // tied gates see no edge
    end
    else
    begin
      gate_q <= gate_i;

      // counting, gate low freezes everything
      if (tick_i && gate_i && (run || load_pend))
      begin
        count     <= next_cnt;
        out_o     <= next_out;
        run       <= 1'b1;
        load_pend <= 1'b0;
      end
      else if (!gate_i)
        out_o <= 1'b1;  // out forced high while gated off

      // gate rise restarts from N on the next tick
      if (gate_i && !gate_q && run)
        load_pend <= 1'b1;

      // count writes
      if (bus.wrd)
      begin
        case (cw.rw)
          RW_LSB:
          begin
            cr        <= {8'h00, bus.data_w};
            load_pend <= 1'b1;
          end
          RW_MSB:
          begin
            cr        <= {bus.data_w, 8'h00};
            load_pend <= 1'b1;
          end
          RW_WORD:
          begin
            if (wr_msb)
            begin
              cr[15:8]  <= bus.data_w;
              load_pend <= 1'b1;   // count complete after msb
            end
            else
              cr[7:0] <= bus.data_w;
            wr_msb <= ~wr_msb;
          end
          default: ;
        endcase
      end

      // reads, latch released once fully read
      if (bus.rdd)
      begin
        if (cw.rw == RW_WORD)
        begin
          rd_msb <= ~rd_msb;
          if (rd_msb)
            latched <= 1'b0;
        end
        else
          latched <= 1'b0;
      end

      // control byte last, reprogram overrides the rest
      if (ctrl_hit)
      begin
        if (ctrl.latch.rw == RW_LATCH)
        begin
          if (!latched)  // repeated latch ignored until read out
          begin
            ol      <= count;
            latched <= 1'b1;
          end
        end
        else
        begin
          cw        <= ctrl.cw;
          out_o     <= 1'b1;
          run       <= 1'b0;   // wait for a new count
          load_pend <= 1'b0;
          latched   <= 1'b0;
          wr_msb    <= 1'b0;
          rd_msb    <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hdl/timer.sv ====
/*
 * simplified 8254 interval timer, wishbone slave
 * tick interrupt, refresh strobe and gated speaker tone
 */
`timescale 1ns/1ps
`include "timer_defs.svh"

module timer (
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  logic        wb_adr_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  input  logic        wb_we_i,
  output logic        wb_ack_o,
  output logic        wb_tgc_o,   // timer interrupt
  input  logic        tclk_i,     // slow count clock
  output logic        refresh_o,  // counter 1 out
  input  logic        gate2_i,    // speaker gate
  output logic        out2_o      // speaker tone
);

  logic tick;
  logic intr;  // counter 0 out

  timer_cnt_if cnt0_if ();
  timer_cnt_if cnt1_if ();
  timer_cnt_if cnt2_if ();

  timer_wb_port i_port (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_we_i  (wb_we_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_tgc_o (wb_tgc_o),
    .intr_i   (intr),
    .cnt0_if  (cnt0_if.bus),
    .cnt1_if  (cnt1_if.bus),
    .cnt2_if  (cnt2_if.bus)
  );

  timer_tclk_sync i_sync (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .tclk_i   (tclk_i),
    .tick_o   (tick)
  );

  // system tick
  timer_counter #(
    .CNT_NUM (2'd0),
    .CNT_CW0 (`TIMER_CW0_0),
    .CNT_CR0 (`TIMER_CR0_0)
  ) i_cnt0 (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .tick_i   (tick),
    .gate_i   (1'b1),
    .bus      (cnt0_if.counter),
    .out_o    (intr)
  );

  // refresh strobe
  timer_counter #(
    .CNT_NUM (2'd1),
    .CNT_CW0 (`TIMER_CW0_1),
    .CNT_CR0 (`TIMER_CR0_1)
  ) i_cnt1 (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .tick_i   (tick),
    .gate_i   (1'b1),
    .bus      (cnt1_if.counter),
    .out_o    (refresh_o)
  );

  // speaker, only gated counter
  timer_counter #(
    .CNT_NUM (2'd2),
    .CNT_CW0 (`TIMER_CW0_2),
    .CNT_CR0 (`TIMER_CR0_2)
  ) i_cnt2 (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .tick_i   (tick),
    .gate_i   (gate2_i),
    .bus      (cnt2_if.counter),
    .out_o    (out2_o)
  );

endmodule

// ==== verification/timer_tb.sv ====
/*
 * interval timer testbench
 * replays bus, tclk and gate vectors and checks reads, outputs and irq pulses
 */
`timescale 1ns/1ps

module timer_tb;

  localparam int  MAX_VEC    = 128;
  localparam int  ACK_WAIT   = 4;     // cycles allowed for ack
  localparam time CLK_PERIOD = 100;
  localparam time DRIVE_DLY  = 10;    // inputs change after the edge

  // vector opcodes, top nibble
  localparam logic [3:0] OP_WRITE = 4'h1;
  localparam logic [3:0] OP_READ  = 4'h2;
  localparam logic [3:0] OP_TICK  = 4'h3;
  localparam logic [3:0] OP_GATE  = 4'h4;
  localparam logic [3:0] OP_OUT   = 4'h5;
  localparam logic [3:0] OP_END   = 4'hF;

  logic        wb_clk_i;
  logic        rst_i;
  logic        wb_adr_i;
  logic [1:0]  wb_sel_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_stb_i;
  logic        wb_cyc_i;
  logic        wb_we_i;
  logic        wb_ack_o;
  logic        wb_tgc_o;
  logic        tclk_i;
  logic        refresh_o;
  logic        gate2_i;
  logic        out2_o;

  logic [31:0] vec [MAX_VEC];  // {op, adr, sel, pad, data}
  int          n_vec = 0;
  bit          vec_loaded = 1'b0;
  int          tgc_seen = 0;   // irq pulses since start
  int          tgc_base = 0;   // count at last output check

  timer i_dut (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .wb_adr_i  (wb_adr_i),
    .wb_sel_i  (wb_sel_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_stb_i  (wb_stb_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_we_i   (wb_we_i),
    .wb_ack_o  (wb_ack_o),
    .wb_tgc_o  (wb_tgc_o),
    .tclk_i    (tclk_i),
    .refresh_o (refresh_o),
    .gate2_i   (gate2_i),
    .out2_o    (out2_o)
  );

  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  // irq pulses sampled mid cycle
  always @(negedge wb_clk_i)
  begin
    if (wb_tgc_o === 1'b1)
      tgc_seen++;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic value_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first mismatch");
  endtask

  task automatic check_dat(input logic [15:0] got, input logic [15:0] exp, input int idx);
    if (got !== exp)
      value_error($sformatf("vector %0d read data %h, expected %h", idx, got, exp));
  endtask

  // {refresh_o, out2_o}
  task automatic compare_outputs(input logic [1:0] got, input logic [1:0] exp,
                                 input int idx);
    if (got !== exp)
      value_error($sformatf("vector %0d refresh/out2 %b, expected %b", idx, got, exp));
  endtask

  task automatic verify_tgc_count(input int got, input int exp, input int idx);
    if (got != exp)
      value_error($sformatf("vector %0d saw %0d tgc pulses, expected %0d", idx, got, exp));
  endtask

  // one single-cycle wishbone access
  task automatic bus_cycle(input logic we, input logic adr, input logic [1:0] sel,
                           input logic [15:0] wdat, output logic [15:0] rdat);
    int waited;
    waited = 0;
    @(posedge wb_clk_i);
    #DRIVE_DLY;
    wb_adr_i = adr;
    wb_sel_i = sel;
    wb_dat_i = wdat;
    wb_we_i  = we;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    @(negedge wb_clk_i);
    while (wb_ack_o !== 1'b1)
    begin
      waited++;
      if (waited == ACK_WAIT)
        abort_run("timer never acknowledged the bus access");
      @(negedge wb_clk_i);
    end
    rdat = wb_dat_o;  // combinational, stable mid cycle
    @(posedge wb_clk_i);
    #DRIVE_DLY;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_sel_i = 2'b00;
  endtask

  // tclk pulses 8 bus cycles apart, 4 high 4 low
  task automatic pulse_tclk(input int count);
    repeat (count)
    begin
      @(posedge wb_clk_i);
      #DRIVE_DLY;
      tclk_i = 1'b1;
      repeat (4) @(posedge wb_clk_i);
      #DRIVE_DLY;
      tclk_i = 1'b0;
      repeat (3) @(posedge wb_clk_i);
    end
  endtask

  // budget grows with the vector count
  initial
  begin
    wait (vec_loaded);
    #((n_vec * 16 + 100) * CLK_PERIOD);
    abort_run("watchdog expired, the vectors did not finish in time");
  end

  initial
  begin
    logic [31:0] v;
    logic [15:0] rdat;
    int          idx;
    $timeformat(-9, 0, " ns", 0);
    wb_clk_i = 1'b0;
    rst_i    = 1'b1;
    wb_adr_i = 1'b0;
    wb_sel_i = 2'b00;
    wb_dat_i = 16'h0000;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    tclk_i   = 1'b0;
    gate2_i  = 1'b1;

    $readmemh("verification/timer_vectors.txt", vec);
    while (n_vec < MAX_VEC && vec[n_vec][31:28] !== OP_END && !$isunknown(vec[n_vec]))
      n_vec++;
    if (n_vec == MAX_VEC || vec[n_vec][31:28] !== OP_END)
      abort_run("vector file missing, unreadable or without an end record");
    vec_loaded = 1'b1;

    repeat (4) @(posedge wb_clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;

    for (idx = 0; idx < n_vec; idx++)
    begin
      v = vec[idx];
      case (v[31:28])
        OP_WRITE: bus_cycle(1'b1, v[24], v[21:20], v[15:0], rdat);
        OP_READ:
        begin
          bus_cycle(1'b0, v[24], v[21:20], 16'h0000, rdat);
          check_dat(rdat, v[15:0], idx);
        end
        OP_TICK:  pulse_tclk(v[15:0]);
        OP_GATE:
        begin
          @(posedge wb_clk_i);
          #DRIVE_DLY;
          gate2_i = v[0];
        end
        OP_OUT:
        begin
          @(negedge wb_clk_i);
          compare_outputs({refresh_o, out2_o}, v[9:8], idx);
          verify_tgc_count(tgc_seen - tgc_base, v[7:0], idx);
          tgc_base = tgc_seen;
        end
        default: abort_run($sformatf("vector %0d has unknown opcode %h", idx, v[31:28]));
      endcase
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== timer.f ====
+incdir+include
hdl/timer_pkg.sv
hdl/timer_cnt_if.sv
hdl/timer_tclk_sync.sv
hdl/timer_wb_port.sv
hdl/timer_counter.sv
hdl/timer.sv
verification/timer_tb.sv

// ==== Bender.yml ====
package:
  name: timer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/timer_pkg.sv
      - hdl/timer_cnt_if.sv
      - hdl/timer_tclk_sync.sv
      - hdl/timer_wb_port.sv
      - hdl/timer_counter.sv
      - hdl/timer.sv
  - target: test
    files:
      - verification/timer_tb.sv

// ==== verification/timer_vectors.txt ====
// word: op adr sel 0 data(4), op 1 write 2 read-expect 3 ticks 4 gate 5 outputs f end
// outputs data: [9:8] expected {refresh_o, out2_o}, [7:0] tgc pulses since last check
11208000  // latch counter 2 at reset
211000A9  // reset reload 04a9, low byte
21100004  // high byte
50000300  // both outputs high, no irq
11205400  // counter 1 lsb only, mode 2
10200500  // n = 5 on the high lane
30000001
50000300  // load tick
30000003
50000300  // count 2
30000001
50000100  // refresh low at 1
30000001
50000300  // reloaded
30000003
50000300
30000001
50000100  // low again, one in five
11209600  // counter 2 lsb only, mode 3
11100006  // n = 6
30000003
50000300  // high for 3
30000001
50000200  // low
30000002
50000200  // still low after 3
30000001
50000300  // high again
1120B600  // counter 2 lsb/msb, mode 3
11100005  // n = 5 low byte
11100000  // high byte
30000003
50000100  // out2 high 3, refresh low
30000001
50000200
30000001
50000200  // low for 2
30000001
50000300
11208000  // latch counter 2, count 5
30000002
21100005  // frozen low byte
30000001
21100000  // frozen high byte, latch released
21100002  // live count
21100000
50000200
40000000  // gate low
30000002
50000300  // out2 forced high
21100002  // count held
21100000
40000001  // gate rises
30000001
21100005  // restarted from n
21100000
30000003
50000200
11203600  // counter 0 lsb/msb, mode 3
10100004  // n = 4
10100000
30000001
50000200  // load tick, no irq yet
3000000C
50000103  // 12 ticks, 3 irq pulses
F0000000  // end
